//--- hdl/core_defs.svh
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// data and address width
`define XLEN 32

// architectural registers, x0 included
`define REG_COUNT 32

// first fetch address after reset
`define RESET_PC 32'h0000_0000

`define ILEN 32

`endif

//--- hdl/rv_isa_pkg.sv
`include "core_defs.svh"

package rv_isa_pkg;

  // major opcodes, instr[6:2]
  localparam logic [4:0] opc_load   = 5'b00000;
  localparam logic [4:0] opc_store  = 5'b01000;
  localparam logic [4:0] opc_branch = 5'b11000;
  localparam logic [4:0] opc_jal    = 5'b11011;
  localparam logic [4:0] opc_jalr   = 5'b11001;
  localparam logic [4:0] opc_op     = 5'b01100;
  localparam logic [4:0] opc_op_imm = 5'b00100;
  localparam logic [4:0] opc_lui    = 5'b01101;
  localparam logic [4:0] opc_auipc  = 5'b00101;
  localparam logic [4:0] opc_system = 5'b11100;

  // one entry per rv32i instruction
  typedef enum logic [5:0] {
    op_illegal,
    op_system,
    op_lui,
    op_auipc,
    op_jal,
    op_jalr,
    op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu,
    op_lb, op_lh, op_lw, op_lbu, op_lhu,
    op_sb, op_sh, op_sw,
    op_addi, op_slti, op_sltiu, op_xori, op_ori, op_andi,
    op_slli, op_srli, op_srai,
    op_add, op_sub, op_sll, op_slt, op_sltu,
    op_xor, op_srl, op_sra, op_or, op_and
  } rv_op_e;

  typedef struct packed {
    rv_op_e            op;
    logic [4:0]        rd;
    logic [4:0]        rs1;
    logic [4:0]        rs2;
    // sign-extended for the instruction format
    logic [`XLEN-1:0]  imm;
  } dec_instr_t;

endpackage

//--- hdl/core_bus_pkg.sv
`include "core_defs.svh"

package core_bus_pkg;

  typedef struct packed {
    logic              valid;
    logic              instr;
    logic [`XLEN-1:0]  addr;
    logic [`XLEN-1:0]  wdata;
    logic [3:0]        wstrb;
  } mem_req_t;

  typedef struct packed {
    logic [`XLEN-1:0]  rd_data;
    logic [`XLEN-1:0]  next_pc;
    logic [`XLEN-1:0]  ls_addr;
    // already replicated across byte lanes
    logic [`XLEN-1:0]  store_data;
    logic [3:0]        wstrb;
    logic              misaligned;
    logic              writes_rd;
  } exec_result_t;

  typedef enum logic [3:0] {
    fetch,
    wait_instr,
    execute,
    wait_load,
    wait_store,
    check_pc,
    reg_write,
    halted
  } core_state_e;

endpackage

//--- hdl/rv_decoder.sv
`timescale 1ns/10ps
`include "core_defs.svh"

module rv_decoder import rv_isa_pkg::*; (
  input  logic [`ILEN-1:0] instr,
  output dec_instr_t       dec
);

  logic [4:0]       opcode;
  logic [2:0]       funct3;
  logic [6:0]       funct7;
  logic [`XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;

  assign opcode = instr[6:2];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    dec.op  = op_illegal;
    dec.rd  = instr[11:7];
    dec.rs1 = instr[19:15];
    dec.rs2 = instr[24:20];
    dec.imm = imm_i;
    // low bits other than 11 would be a compressed encoding
    if (instr[1:0] == 2'b11) begin
      case (opcode)
        opc_lui: begin
          dec.op  = op_lui;
          dec.imm = imm_u;
        end
        opc_auipc: begin
          dec.op  = op_auipc;
          dec.imm = imm_u;
        end
        opc_jal: begin
          dec.op  = op_jal;
          dec.imm = imm_j;
        end
        opc_jalr: begin
          if (funct3 == 3'b000) dec.op = op_jalr;
        end
        opc_branch: begin
          dec.imm = imm_b;
          case (funct3)
            3'b000:  dec.op = op_beq;
            3'b001:  dec.op = op_bne;
            3'b100:  dec.op = op_blt;
            3'b101:  dec.op = op_bge;
            3'b110:  dec.op = op_bltu;
            3'b111:  dec.op = op_bgeu;
            default: dec.op = op_illegal;
          endcase
        end
        opc_load: begin
          case (funct3)
            3'b000:  dec.op = op_lb;
            3'b001:  dec.op = op_lh;
            3'b010:  dec.op = op_lw;
            3'b100:  dec.op = op_lbu;
            3'b101:  dec.op = op_lhu;
            default: dec.op = op_illegal;
          endcase
        end
        opc_store: begin
          dec.imm = imm_s;
          case (funct3)
            3'b000:  dec.op = op_sb;
            3'b001:  dec.op = op_sh;
            3'b010:  dec.op = op_sw;
            default: dec.op = op_illegal;
          endcase
        end
        opc_op_imm: begin
          case (funct3)
            3'b000: dec.op = op_addi;
            3'b010: dec.op = op_slti;
            3'b011: dec.op = op_sltiu;
            3'b100: dec.op = op_xori;
            3'b110: dec.op = op_ori;
            3'b111: dec.op = op_andi;
            3'b001: if (funct7 == 7'b0000000) dec.op = op_slli;
            3'b101: begin
              if (funct7 == 7'b0000000) dec.op = op_srli;
              else if (funct7 == 7'b0100000) dec.op = op_srai;
            end
            default: dec.op = op_illegal;
          endcase
        end
        opc_op: begin
          case ({funct7, funct3})
            10'b0000000_000: dec.op = op_add;
            10'b0100000_000: dec.op = op_sub;
            10'b0000000_001: dec.op = op_sll;
            10'b0000000_010: dec.op = op_slt;
            10'b0000000_011: dec.op = op_sltu;
            10'b0000000_100: dec.op = op_xor;
            10'b0000000_101: dec.op = op_srl;
            10'b0100000_101: dec.op = op_sra;
            10'b0000000_110: dec.op = op_or;
            10'b0000000_111: dec.op = op_and;
            default:         dec.op = op_illegal;
          endcase
        end
        opc_system: begin
          // only ecall and ebreak, everything else in this space is illegal
          if (instr[31:7] == 25'h0 || instr[31:7] == {12'h001, 13'h0}) dec.op = op_system;
        end
        default: dec.op = op_illegal;
      endcase
    end
  end

endmodule

//--- hdl/rv_execute.sv
`timescale 1ns/10ps
`include "core_defs.svh"

module rv_execute import rv_isa_pkg::*, core_bus_pkg::*; (
  input  dec_instr_t       dec,
  input  logic [`XLEN-1:0] pc,
  input  logic [`XLEN-1:0] rs1_data,
  input  logic [`XLEN-1:0] rs2_data,
  output exec_result_t     result
);

  logic [`XLEN-1:0] operand_b, pc_plus4, ls_addr;
  logic [4:0]       shamt;
  logic             taken, size_fault;

  // register ops take rs2, everything else the immediate
  assign operand_b = (dec.op inside {op_add, op_sub, op_sll, op_slt, op_sltu,
                                     op_xor, op_srl, op_sra, op_or, op_and}) ? rs2_data : dec.imm;
  assign shamt    = operand_b[4:0];
  assign pc_plus4 = pc + `XLEN'd4;
  assign ls_addr  = rs1_data + dec.imm;

  always_comb begin
    case (dec.op)
      op_beq:  taken = rs1_data == rs2_data;
      op_bne:  taken = rs1_data != rs2_data;
      op_blt:  taken = $signed(rs1_data) < $signed(rs2_data);
      op_bge:  taken = $signed(rs1_data) >= $signed(rs2_data);
      op_bltu: taken = rs1_data < rs2_data;
      op_bgeu: taken = rs1_data >= rs2_data;
      default: taken = 1'b0;
    endcase
  end

  always_comb begin
    case (dec.op)
      op_add, op_addi:   result.rd_data = rs1_data + operand_b;
      op_sub:            result.rd_data = rs1_data - operand_b;
      op_sll, op_slli:   result.rd_data = rs1_data << shamt;
      op_slt, op_slti:   result.rd_data = {31'b0, $signed(rs1_data) < $signed(operand_b)};
      op_sltu, op_sltiu: result.rd_data = {31'b0, rs1_data < operand_b};
      op_xor, op_xori:   result.rd_data = rs1_data ^ operand_b;
      op_srl, op_srli:   result.rd_data = rs1_data >> shamt;
      op_sra, op_srai:   result.rd_data = $signed(rs1_data) >>> shamt;
      op_or, op_ori:     result.rd_data = rs1_data | operand_b;
      op_and, op_andi:   result.rd_data = rs1_data & operand_b;
      op_lui:            result.rd_data = dec.imm;
      op_auipc:          result.rd_data = pc + dec.imm;
      op_jal, op_jalr:   result.rd_data = pc_plus4;
      default:           result.rd_data = '0;
    endcase

    case (dec.op)
      op_jal:  result.next_pc = pc + dec.imm;
      op_jalr: result.next_pc = ls_addr & ~`XLEN'd1;
      op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu:
        result.next_pc = taken ? pc + dec.imm : pc_plus4;
      default: result.next_pc = pc_plus4;
    endcase

    // byte and half stores are copied to every lane, wstrb picks the one
    case (dec.op)
      op_sb: begin
        result.wstrb      = 4'b0001 << ls_addr[1:0];
        result.store_data = {4{rs2_data[7:0]}};
      end
      op_sh: begin
        result.wstrb      = ls_addr[1] ? 4'b1100 : 4'b0011;
        result.store_data = {2{rs2_data[15:0]}};
      end
      op_sw: begin
        result.wstrb      = 4'b1111;
        result.store_data = rs2_data;
      end
      default: begin
        result.wstrb      = 4'b0000;
        result.store_data = rs2_data;
      end
    endcase
  end

  always_comb begin
    case (dec.op)
      op_lw, op_sw:        size_fault = |ls_addr[1:0];
      op_lh, op_lhu, op_sh: size_fault = ls_addr[0];
      default:             size_fault = 1'b0;
    endcase
  end

  assign result.ls_addr    = ls_addr;
  assign result.misaligned = size_fault || |result.next_pc[1:0];
  assign result.writes_rd  = !(dec.op inside {op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu,
                                              op_sb, op_sh, op_sw, op_system, op_illegal});

endmodule

//--- hdl/rv_writeback.sv
`timescale 1ns/10ps
`include "core_defs.svh"

module rv_writeback import rv_isa_pkg::*; (
  input  logic             clk,
  input  logic             reset,
  input  dec_instr_t       dec,
  input  logic             we,
  input  logic             from_load,
  input  logic [`XLEN-1:0] alu_data,
  input  logic [`XLEN-1:0] mem_rdata,
  input  logic [1:0]       ls_offset,
  output logic [`XLEN-1:0] rs1_data,
  output logic [`XLEN-1:0] rs2_data
);

  logic [`XLEN-1:0] regs [`REG_COUNT];
  logic [`XLEN-1:0] load_word, load_data, wr_data;
  logic [7:0]       lane_byte;
  logic [15:0]      lane_half;

  // follows the bus while waiting on a load, holds the last word once written back
  always_ff @(posedge clk) begin
    if (from_load && !we) load_word <= mem_rdata;
  end

  assign lane_byte = load_word[8*ls_offset +: 8];
  assign lane_half = ls_offset[1] ? load_word[31:16] : load_word[15:0];

  always_comb begin
    case (dec.op)
      op_lb:   load_data = {{24{lane_byte[7]}}, lane_byte};
      op_lbu:  load_data = {24'b0, lane_byte};
      op_lh:   load_data = {{16{lane_half[15]}}, lane_half};
      op_lhu:  load_data = {16'b0, lane_half};
      default: load_data = load_word;
    endcase
  end

  assign wr_data = from_load ? load_data : alu_data;

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (we && dec.rd != 5'd0) begin
      regs[dec.rd] <= wr_data;
    end
  end

  // x0 reads as zero
  assign rs1_data = (dec.rs1 == 5'd0) ? '0 : regs[dec.rs1];
  assign rs2_data = (dec.rs2 == 5'd0) ? '0 : regs[dec.rs2];

endmodule

//--- hdl/rv_sequencer.sv
`timescale 1ns/10ps
`include "core_defs.svh"

module rv_sequencer import rv_isa_pkg::*, core_bus_pkg::*; (
  input  logic             clk,
  input  logic             reset,
  output mem_req_t         mem_req,
  input  logic             mem_ready,
  input  logic [`XLEN-1:0] mem_rdata,
  output logic [`ILEN-1:0] instr,
  output logic [`XLEN-1:0] pc,
  input  dec_instr_t       dec,
  input  exec_result_t     result,
  output logic             we,
  output logic             from_load,
  output logic [`XLEN-1:0] alu_data,
  output logic [1:0]       ls_offset,
  output logic             trap
);

  core_state_e      state;
  logic [`XLEN-1:0] next_pc;
  logic             writes_rd;
  logic             is_load, is_store;

  assign is_load  = dec.op inside {op_lb, op_lh, op_lw, op_lbu, op_lhu};
  assign is_store = dec.op inside {op_sb, op_sh, op_sw};

  always_ff @(posedge clk) begin
    if (reset) begin
      state         <= fetch;
      pc            <= `RESET_PC;
      mem_req.valid <= 1'b0;
      mem_req.instr <= 1'b0;
      mem_req.wstrb <= 4'b0000;
    end else begin
      case (state)
        fetch: begin
          mem_req.valid <= 1'b1;
          mem_req.instr <= 1'b1;
          mem_req.addr  <= pc;
          mem_req.wstrb <= 4'b0000;
          state         <= wait_instr;
        end
        wait_instr: begin
          if (mem_ready) begin
            mem_req.valid <= 1'b0;
            instr         <= mem_rdata;
            state         <= execute;
          end
        end
        execute: begin
          alu_data  <= result.rd_data;
          next_pc   <= result.next_pc;
          ls_offset <= result.ls_addr[1:0];
          writes_rd <= result.writes_rd;
          if (dec.op == op_illegal || dec.op == op_system || result.misaligned) begin
            state <= halted;
          end else if (is_load || is_store) begin
            // data accesses always go out word aligned
            mem_req.valid <= 1'b1;
            mem_req.instr <= 1'b0;
            mem_req.addr  <= {result.ls_addr[`XLEN-1:2], 2'b00};
            mem_req.wdata <= result.store_data;
            mem_req.wstrb <= result.wstrb;
            state         <= is_load ? wait_load : wait_store;
          end else begin
            state <= check_pc;
          end
        end
        wait_load: begin
          if (mem_ready) begin
            mem_req.valid <= 1'b0;
            pc            <= next_pc;
            state         <= reg_write;
          end
        end
        wait_store: begin
          if (mem_ready) begin
            mem_req.valid <= 1'b0;
            mem_req.wstrb <= 4'b0000;
            pc            <= next_pc;
            state         <= fetch;
          end
        end
        check_pc: begin
          pc    <= next_pc;
          state <= writes_rd ? reg_write : fetch;
        end
        reg_write: state <= fetch;
        default:   state <= halted;
      endcase
    end
  end

  // load word is captured while waiting and selected during the write
  assign we        = state == reg_write;
  assign from_load = state == wait_load || (state == reg_write && is_load);
  assign trap      = state == halted;

endmodule

//--- hdl/rv_core.sv
`timescale 1ns/10ps
`include "core_defs.svh"

module rv_core import rv_isa_pkg::*, core_bus_pkg::*; (
  input  logic             clk,
  input  logic             reset,
  output mem_req_t         mem_req,
  input  logic             mem_ready,
  input  logic [`XLEN-1:0] mem_rdata,
  output logic             trap
);

  logic [`ILEN-1:0] instr;
  logic [`XLEN-1:0] pc, rs1_data, rs2_data, alu_data;
  logic [1:0]       ls_offset;
  logic             we, from_load;
  dec_instr_t       dec;
  exec_result_t     result;

  rv_sequencer u_sequencer (
    .clk       (clk),
    .reset     (reset),
    .mem_req   (mem_req),
    .mem_ready (mem_ready),
    .mem_rdata (mem_rdata),
    .instr     (instr),
    .pc        (pc),
    .dec       (dec),
    .result    (result),
    .we        (we),
    .from_load (from_load),
    .alu_data  (alu_data),
    .ls_offset (ls_offset),
    .trap      (trap)
  );

  rv_decoder u_decoder (
    .instr (instr),
    .dec   (dec)
  );

  rv_execute u_execute (
    .dec      (dec),
    .pc       (pc),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .result   (result)
  );

  rv_writeback u_writeback (
    .clk       (clk),
    .reset     (reset),
    .dec       (dec),
    .we        (we),
    .from_load (from_load),
    .alu_data  (alu_data),
    .mem_rdata (mem_rdata),
    .ls_offset (ls_offset),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data)
  );

endmodule

//--- verif/rv_core_props.sv
`timescale 1ns/10ps

module rv_core_props import core_bus_pkg::*; (
  input logic     clk,
  input logic     reset,
  input mem_req_t mem_req,
  input logic     mem_ready,
  input logic     trap
);

  int error_count = 0;

  // request fields hold until the ready cycle
  a_req_stable: assert property (@(posedge clk) disable iff (reset)
    mem_req.valid && !mem_ready |=>
      mem_req.valid && $stable(mem_req.addr) && $stable(mem_req.wstrb))
    else begin
      $error("memory request dropped or changed before ready");
      error_count++;
    end

  a_fetch_no_write: assert property (@(posedge clk) disable iff (reset)
    mem_req.valid && mem_req.instr |-> mem_req.wstrb == 4'b0000)
    else begin
      $error("instruction fetch carries write strobes");
      error_count++;
    end

  // once halted, only reset leaves the trap state
  a_trap_sticky: assert property (@(posedge clk) disable iff (reset)
    trap |=> trap)
    else begin
      $error("trap fell without a reset");
      error_count++;
    end

endmodule

bind rv_sequencer rv_core_props u_props (.*);

//--- verif/rv_core_checker.sv
`timescale 1ns/10ps
`include "core_defs.svh"

module rv_core_checker import core_bus_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  mem_req_t    mem_req,
  input  logic        mem_ready,
  input  logic        trap,
  input  logic        arm,
  input  logic        exp_write,
  input  logic [31:0] exp_data,
  input  logic [3:0]  exp_strb,
  input  logic [95:0] name,
  output logic        done,
  output int          pass_count,
  output int          fail_count
);

  // every program stores its result word here
  localparam logic [31:0] result_addr = 32'h0000_0200;

  logic failed;
  logic seen_write;
  logic seen_req;
  int   post_cycles;
  logic bad;

  initial begin
    pass_count = 0;
    fail_count = 0;
    done       = 1'b0;
  end

  always @(posedge clk) begin
    if (reset) begin
      done        <= 1'b0;
      failed      <= 1'b0;
      seen_write  <= 1'b0;
      seen_req    <= 1'b0;
      post_cycles <= 0;
    end else if (arm && !done) begin
      // the first request after reset fetches from the reset pc
      if (mem_req.valid && !seen_req) begin
        if (!mem_req.instr || mem_req.addr != `RESET_PC) begin
          $display("Fail %0s expected fetch at %h actual instr %b addr %h", name, `RESET_PC,
                   mem_req.instr, mem_req.addr);
          failed <= 1'b1;
        end
        seen_req <= 1'b1;
      end

      if (mem_req.valid && mem_ready && mem_req.wstrb != 4'b0000) begin
        if (!exp_write) begin
          $display("%0s: the core wrote to memory although it should have trapped", name);
          failed <= 1'b1;
        end else if (seen_write) begin
          $display("%0s: the core wrote to memory more than once", name);
          failed <= 1'b1;
        end else if (mem_req.instr || mem_req.addr != result_addr) begin
          $display("Fail %0s expected data write at %h actual %h with instr %b", name,
                   result_addr, mem_req.addr, mem_req.instr);
          failed <= 1'b1;
        end else if (mem_req.wdata != exp_data || mem_req.wstrb != exp_strb) begin
          $display("Fail %0s expected %h/%b actual %h/%b", name, exp_data, exp_strb,
                   mem_req.wdata, mem_req.wstrb);
          failed <= 1'b1;
        end
        seen_write <= 1'b1;
      end

      // watch a few cycles after the trap for stray requests
      if (trap) begin
        if (post_cycles < 4) begin
          if (mem_req.valid) begin
            $display("%0s: a memory request was issued after the trap", name);
            failed <= 1'b1;
          end
          post_cycles <= post_cycles + 1;
        end else begin
          bad = failed;
          if (exp_write && !seen_write) begin
            $display("%0s: the core trapped without writing its result", name);
            bad = 1'b1;
          end
          if (bad) begin
            fail_count = fail_count + 1;
            $display("%0s: failed", name);
          end else begin
            pass_count = pass_count + 1;
            $display("%0s: ok", name);
          end
          done <= 1'b1;
        end
      end
    end
  end

endmodule

//--- verif/tb_rv_core.sv
`timescale 1ns/10ps

module tb_rv_core import rv_isa_pkg::*, core_bus_pkg::*;;

  localparam int num_tests      = 46;
  localparam int max_prog_words = 10;
  localparam int timeout_cycles = num_tests * max_prog_words * 20;
  localparam logic [31:0] seed  = 32'h00a84bf6;
  localparam logic [31:0] ebreak_word = 32'h0010_0073;

  logic        clk;
  logic        reset;
  mem_req_t    mem_req;
  logic        mem_ready;
  logic [31:0] mem_rdata;
  logic        trap;

  logic        arm;
  logic        exp_write;
  logic [31:0] exp_data;
  logic [3:0]  exp_strb;
  logic [95:0] exp_name;
  logic        done;
  int          pass_count;
  int          fail_count;

  logic [31:0] mem [256];
  logic [31:0] prog [$];
  logic [31:0] preload_word;
  logic        preload_en;
  logic [31:0] stim_rng;
  logic [31:0] mem_rng;
  logic        pending;
  logic [1:0]  wait_left;
  logic [1:0]  wait_cur;
  int          cycles;

  rv_core DUT (
    .clk       (clk),
    .reset     (reset),
    .mem_req   (mem_req),
    .mem_ready (mem_ready),
    .mem_rdata (mem_rdata),
    .trap      (trap)
  );

  rv_core_checker u_checker (
    .clk        (clk),
    .reset      (reset),
    .mem_req    (mem_req),
    .mem_ready  (mem_ready),
    .trap       (trap),
    .arm        (arm),
    .exp_write  (exp_write),
    .exp_data   (exp_data),
    .exp_strb   (exp_strb),
    .name       (exp_name),
    .done       (done),
    .pass_count (pass_count),
    .fail_count (fail_count)
  );

  always #4 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    stim_rng = xorshift(stim_rng);
    return stim_rng;
  endfunction

  // memory model, answers after 1 to 4 cycles
  always @(posedge clk) begin
    if (reset) begin
      mem_ready <= 1'b0;
      pending   <= 1'b0;
    end else if (mem_ready) begin
      mem_ready <= 1'b0;
      pending   <= 1'b0;
    end else if (mem_req.valid) begin
      if (!pending) begin
        mem_rng  = xorshift(mem_rng);
        wait_cur = mem_rng[1:0];
      end else begin
        wait_cur = wait_left;
      end
      pending <= 1'b1;
      if (wait_cur == 2'd0) begin
        mem_ready <= 1'b1;
        mem_rdata <= mem[mem_req.addr[9:2]];
        for (int b = 0; b < 4; b++) begin
          if (mem_req.wstrb[b]) mem[mem_req.addr[9:2]][8*b +: 8] <= mem_req.wdata[8*b +: 8];
        end
      end else begin
        wait_left <= wait_cur - 2'd1;
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= timeout_cycles) begin
      $display("timeout, the core did not finish all tests in time");
      $display("test failed");
      $finish;
    end
  end

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, opc_op, 2'b11};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [4:0] opc);
    return {imm, rs1, f3, rd, opc, 2'b11};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], opc_store, 2'b11};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc_branch, 2'b11};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc_jal, 2'b11};
  endfunction

  // expected register value for alu instructions, b already sign-extended
  function automatic logic [31:0] ref_alu(input logic [95:0] op, input logic [31:0] a,
                                          input logic [31:0] b);
    case (op)
      "add", "addi":   return a + b;
      "sub":           return a - b;
      "sll", "slli":   return a << b[4:0];
      "slt", "slti":   return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      "sltu", "sltiu": return (a < b) ? 32'd1 : 32'd0;
      "xor", "xori":   return a ^ b;
      "srl", "srli":   return a >> b[4:0];
      "sra", "srai":   return $unsigned($signed(a) >>> b[4:0]);
      "or", "ori":     return a | b;
      default:         return a & b;
    endcase
  endfunction

  function automatic logic ref_branch(input logic [95:0] op, input logic [31:0] a,
                                      input logic [31:0] b);
    case (op)
      "beq":   return a == b;
      "bne":   return a != b;
      "blt":   return $signed(a) < $signed(b);
      "bge":   return $signed(a) >= $signed(b);
      "bltu":  return a < b;
      default: return a >= b;
    endcase
  endfunction

  function automatic logic [31:0] ref_load(input logic [95:0] op, input logic [31:0] w,
                                           input logic [1:0] off);
    logic [31:0] s;
    s = w >> (8 * off);
    case (op)
      "lb":    return {{24{s[7]}}, s[7:0]};
      "lbu":   return {24'b0, s[7:0]};
      "lh":    return {{16{s[15]}}, s[15:0]};
      default: return {16'b0, s[15:0]};
    endcase
  endfunction

  task automatic load_const(input logic [4:0] rd, input logic [31:0] v);
    logic [31:0] hi;
    hi = (v + 32'h800) >> 12;
    prog.push_back({hi[19:0], rd, opc_lui, 2'b11});
    prog.push_back(enc_i(v[11:0], rd, 3'b000, rd, opc_op_imm));
  endtask

  // result word to 0x200, then halt
  task automatic finish_prog(input logic [4:0] rs);
    prog.push_back(enc_s(12'h200, rs, 5'd0, 3'b010));
    prog.push_back(ebreak_word);
  endtask

  task automatic run_test(input logic [95:0] name, input logic want_write,
                          input logic [31:0] data, input logic [3:0] strb);
    @(posedge clk);
    reset <= 1'b1;
    arm   <= 1'b0;
    for (int i = 0; i < 256; i++) begin
      mem[i] = {22'h0, i[7:0], 2'b00};
    end
    foreach (prog[i]) mem[i] = prog[i];
    if (preload_en) mem[64] = preload_word;
    exp_name  <= name;
    exp_write <= want_write;
    exp_data  <= data;
    exp_strb  <= strb;
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    arm   <= 1'b1;
    @(posedge clk);
    while (!done) @(posedge clk);
    arm <= 1'b0;
    prog.delete();
    preload_en = 1'b0;
  endtask

  task automatic alu_reg_test(input logic [95:0] name, input logic [2:0] f3,
                              input logic [6:0] f7);
    logic [31:0] a, b;
    a = next_rand();
    b = next_rand();
    load_const(5'd1, a);
    load_const(5'd2, b);
    prog.push_back(enc_r(f7, 5'd2, 5'd1, f3, 5'd3));
    finish_prog(5'd3);
    run_test(name, 1'b1, ref_alu(name, a, b), 4'hf);
  endtask

  task automatic alu_imm_test(input logic [95:0] name, input logic [2:0] f3,
                              input logic is_shift, input logic [6:0] f7);
    logic [31:0] a, r;
    logic [11:0] imm;
    a   = next_rand();
    r   = next_rand();
    imm = is_shift ? {f7, r[4:0]} : r[11:0];
    load_const(5'd1, a);
    prog.push_back(enc_i(imm, 5'd1, f3, 5'd3, opc_op_imm));
    finish_prog(5'd3);
    run_test(name, 1'b1, ref_alu(name, a, {{20{imm[11]}}, imm}), 4'hf);
  endtask

  task automatic branch_test(input logic [95:0] name, input logic [2:0] f3);
    logic [31:0] a, b, r;
    a = next_rand();
    r = next_rand();
    b = r[0] ? a : next_rand();
    load_const(5'd1, a);
    load_const(5'd2, b);
    prog.push_back(enc_b(13'd12, 5'd2, 5'd1, f3));
    prog.push_back(enc_i(12'd2, 5'd0, 3'b000, 5'd3, opc_op_imm));
    prog.push_back(enc_j(21'd8, 5'd0));
    prog.push_back(enc_i(12'd1, 5'd0, 3'b000, 5'd3, opc_op_imm));
    finish_prog(5'd3);
    run_test(name, 1'b1, ref_branch(name, a, b) ? 32'd1 : 32'd2, 4'hf);
  endtask

  task automatic jal_test();
    logic [31:0] jal_addr;
    prog.push_back(enc_i(12'd0, 5'd0, 3'b000, 5'd0, opc_op_imm));
    prog.push_back(enc_i(12'd0, 5'd0, 3'b000, 5'd0, opc_op_imm));
    jal_addr = prog.size() * 4;
    prog.push_back(enc_j(21'd8, 5'd5));
    prog.push_back(enc_i(12'd0, 5'd0, 3'b000, 5'd0, opc_op_imm));
    finish_prog(5'd5);
    run_test("jal", 1'b1, jal_addr + 32'd4, 4'hf);
  endtask

  // sub-word stores go straight to the result address
  task automatic store_test(input logic [95:0] name, input int size, input logic [1:0] off);
    logic [31:0] v, data;
    logic [3:0]  strb;
    v = next_rand();
    load_const(5'd2, v);
    prog.push_back(enc_s(12'h200 + off, 5'd2, 5'd0, (size == 1) ? 3'b000 : 3'b001));
    prog.push_back(ebreak_word);
    // each lane carries the value byte of its position within the access size
    for (int b = 0; b < 4; b++) begin
      strb[b]        = (b >= off) && (b < off + size);
      data[8*b +: 8] = v[8*(b % size) +: 8];
    end
    run_test(name, 1'b1, data, strb);
  endtask

  task automatic load_test(input logic [95:0] name, input logic [2:0] f3,
                           input logic [1:0] off);
    preload_word = next_rand();
    preload_en   = 1'b1;
    prog.push_back(enc_i(12'h100 + off, 5'd0, f3, 5'd3, opc_load));
    finish_prog(5'd3);
    run_test(name, 1'b1, ref_load(name, preload_word, off), 4'hf);
  endtask

  initial begin
    clk          = 1'b0;
    reset        = 1'b1;
    mem_ready    = 1'b0;
    mem_rdata    = '0;
    arm          = 1'b0;
    exp_write    = 1'b0;
    exp_data     = '0;
    exp_strb     = '0;
    exp_name     = '0;
    preload_en   = 1'b0;
    preload_word = '0;
    pending      = 1'b0;
    wait_left    = '0;
    cycles       = 0;
    stim_rng     = seed;
    mem_rng      = seed;

    alu_reg_test("add", 3'b000, 7'h00);
    alu_reg_test("sub", 3'b000, 7'h20);
    alu_reg_test("sll", 3'b001, 7'h00);
    alu_reg_test("slt", 3'b010, 7'h00);
    alu_reg_test("sltu", 3'b011, 7'h00);
    alu_reg_test("xor", 3'b100, 7'h00);
    alu_reg_test("srl", 3'b101, 7'h00);
    alu_reg_test("sra", 3'b101, 7'h20);
    alu_reg_test("or", 3'b110, 7'h00);
    alu_reg_test("and", 3'b111, 7'h00);

    alu_imm_test("addi", 3'b000, 1'b0, 7'h00);
    alu_imm_test("slti", 3'b010, 1'b0, 7'h00);
    alu_imm_test("sltiu", 3'b011, 1'b0, 7'h00);
    alu_imm_test("xori", 3'b100, 1'b0, 7'h00);
    alu_imm_test("ori", 3'b110, 1'b0, 7'h00);
    alu_imm_test("andi", 3'b111, 1'b0, 7'h00);
    alu_imm_test("slli", 3'b001, 1'b1, 7'h00);
    alu_imm_test("srli", 3'b101, 1'b1, 7'h00);
    alu_imm_test("srai", 3'b101, 1'b1, 7'h20);

    branch_test("beq", 3'b000);
    branch_test("bne", 3'b001);
    branch_test("blt", 3'b100);
    branch_test("bge", 3'b101);
    branch_test("bltu", 3'b110);
    branch_test("bgeu", 3'b111);
    jal_test();

    for (int off = 0; off < 4; off++) begin
      store_test("sb", 1, off[1:0]);
    end
    store_test("sh", 2, 2'd0);
    store_test("sh", 2, 2'd2);

    for (int off = 0; off < 4; off++) begin
      load_test("lb", 3'b000, off[1:0]);
      load_test("lbu", 3'b100, off[1:0]);
    end
    for (int off = 0; off < 4; off += 2) begin
      load_test("lh", 3'b001, off[1:0]);
      load_test("lhu", 3'b101, off[1:0]);
    end

    // no write expected, only the trap
    prog.push_back(enc_i(12'h101, 5'd0, 3'b010, 5'd3, opc_load));
    finish_prog(5'd3);
    run_test("lw_misalign", 1'b0, 32'h0, 4'h0);
    prog.push_back(32'hffff_ffff);
    finish_prog(5'd0);
    run_test("illegal", 1'b0, 32'h0, 4'h0);

    $display("%0d tests passed, %0d tests failed, %0d assertion errors",
             pass_count, fail_count, DUT.u_sequencer.u_props.error_count);
    if (fail_count == 0 && DUT.u_sequencer.u_props.error_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

//--- files.f
+incdir+hdl
hdl/rv_isa_pkg.sv
hdl/core_bus_pkg.sv
hdl/rv_decoder.sv
hdl/rv_execute.sv
hdl/rv_writeback.sv
hdl/rv_sequencer.sv
hdl/rv_core.sv
verif/rv_core_props.sv
verif/rv_core_checker.sv
verif/tb_rv_core.sv

//--- Bender.yml
package:
  name: rv_core

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/rv_isa_pkg.sv
      - hdl/core_bus_pkg.sv
      - hdl/rv_decoder.sv
      - hdl/rv_execute.sv
      - hdl/rv_writeback.sv
      - hdl/rv_sequencer.sv
      - hdl/rv_core.sv
  - target: simulation
    files:
      - verif/rv_core_props.sv
      - verif/rv_core_checker.sv
      - verif/tb_rv_core.sv
